/* commit.f */
+incdir+common
common/commitPkg.sv
hw/robHead/robHead.sv
hw/commitStage/commitStage.sv
hw/archMapUpdate.sv
hw/commitTop.sv
verification/commit_sva.sv
verification/commitTb.sv

/* common/commitPkg.sv */
`include "commit_defines.svh"

package commitPkg;

    typedef enum logic [1:0] {
        normal,
        conditional,
        jump
    } branchKind;

    typedef enum logic [1:0] {
        none,
        syscall,
        overflow,
        addrError
    } excKind;

    // one executed micro-op as it sits in the reorder buffer.
    typedef struct packed {
        logic                valid;
        logic                isBubble;    // empty delay-slot filler.
        logic [31:0]         pc;
        branchKind           branchKind;
        logic                branchTaken;
        logic [31:0]         branchAddr;
        logic                predTaken;
        logic [31:0]         predAddr;
        logic                dstWe;
        logic [`AREG_W-1:0]  dstArch;
        logic [`PREG_W-1:0]  dstPhys;
        logic [`PREG_W-1:0]  dstStale;    // previous mapping of dstArch.
        logic                causeExc;
        excKind              excKind;
    } retireEntry;

    typedef struct packed {
        retireEntry slot0;
        retireEntry slot1;
    } retirePair;

    typedef struct packed {
        logic                wrReg;
        logic [`AREG_W-1:0]  archReg;
        logic [`PREG_W-1:0]  physReg;
        logic [`PREG_W-1:0]  staleReg;
    } commitReq;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirectInfo;

endpackage

/* common/commit_defines.svh */
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// reorder-buffer geometry.
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// architectural register index and physical tag widths.
`define AREG_W 5
`define PREG_W 6

// exception handler entry point.
`define EXC_VECTOR 32'hBFC00380

// fall-through past a branch and its delay slot.
`define DS_OFFSET 32'd8

`endif

/* hw/archMapUpdate.sv */
`timescale 1ns/1ps
`include "commit_defines.svh"

module archMapUpdate (
    input  logic                clk,
    input  logic                rstN,
    input  logic                commitValid0,
    input  logic                commitValid1,
    input  commitPkg::commitReq commitReq0,
    input  commitPkg::commitReq commitReq1,
    input  logic [`AREG_W-1:0]  archReadAddr,
    output logic [`PREG_W-1:0]  archReadPhys,
    output logic                freeValid0,
    output logic                freeValid1,
    output logic [`PREG_W-1:0]  freeReg0,
    output logic [`PREG_W-1:0]  freeReg1
);

    localparam int ArchRegs = 1 << `AREG_W;

    logic [`PREG_W-1:0] mapTable [ArchRegs];
    logic               wr0;
    logic               wr1;

    assign wr0 = commitValid0 && commitReq0.wrReg;
    assign wr1 = commitValid1 && commitReq1.wrReg;

    // committed mapping, identity out of reset.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < ArchRegs; i++) begin
                mapTable[i] <= `PREG_W'(i);
            end
        end else begin
            if (wr0 && commitReq0.archReg != '0) begin
                mapTable[commitReq0.archReg] <= commitReq0.physReg;
            end
            // younger slot wins on the same register.
            if (wr1 && commitReq1.archReg != '0) begin
                mapTable[commitReq1.archReg] <= commitReq1.physReg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            freeValid0 <= 1'b0;
            freeValid1 <= 1'b0;
        end else begin
            freeValid0 <= wr0;                // r0 stale tag is freed too.
            freeValid1 <= wr1;
        end
    end

    always_ff @(posedge clk) begin
        freeReg0 <= commitReq0.staleReg;
        freeReg1 <= commitReq1.staleReg;
    end

    assign archReadPhys = mapTable[archReadAddr];

endmodule

/* hw/commitStage/commitStage.sv */
`timescale 1ns/1ps
`include "commit_defines.svh"

module commitStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   retireValid,
    input  commitPkg::retirePair   retire,
    output logic                   flushReq,
    output commitPkg::redirectInfo redirect,
    output commitPkg::excKind      excCode,
    output logic                   commitValid0,
    output logic                   commitValid1,
    output commitPkg::commitReq    commitReq0,
    output commitPkg::commitReq    commitReq1
);

    import commitPkg::*;

    retireEntry  s0;
    retireEntry  s1;
    logic        isBranch0;
    logic        dirMiss;
    logic        tgtMiss;
    logic        slot1Bubble;
    logic        excNow;
    logic [31:0] target;

    logic        mispredQ;
    logic        waitDelaySlot;
    logic        waitDoneQ;
    logic        excQ;
    excKind      excKindQ;
    logic [31:0] targetQ;

    assign s0 = retire.slot0;
    assign s1 = retire.slot1;

    assign excNow    = retireValid && s0.valid && s0.causeExc;
    assign isBranch0 = retireValid && s0.valid && !s0.isBubble && !s0.causeExc
                       && (s0.branchKind != normal);

    // direction first, target only matters when taken.
    assign dirMiss = isBranch0 && (s0.branchTaken != s0.predTaken);
    assign tgtMiss = isBranch0 && !dirMiss && s0.branchTaken
                     && (s0.branchAddr != s0.predAddr);

    assign slot1Bubble = s1.valid && s1.isBubble;
    assign target      = s0.branchTaken ? s0.branchAddr : s0.pc + `DS_OFFSET;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mispredQ      <= 1'b0;
            waitDelaySlot <= 1'b0;
            waitDoneQ     <= 1'b0;
            excQ          <= 1'b0;
            commitValid0  <= 1'b0;
            commitValid1  <= 1'b0;
        end else begin
            mispredQ  <= (dirMiss || tgtMiss) && !slot1Bubble && !flushReq;
            waitDoneQ <= waitDelaySlot && retireValid && !flushReq;
            excQ      <= excNow && !flushReq;

            if (flushReq) begin
                waitDelaySlot <= 1'b0;
            end else if ((dirMiss || tgtMiss) && slot1Bubble) begin
                waitDelaySlot <= 1'b1;        // delay slot still in flight.
            end else if (retireValid) begin
                waitDelaySlot <= 1'b0;
            end

            // bubbles and faulting ops never commit.
            commitValid0 <= retireValid && s0.valid && !s0.isBubble
                            && !s0.causeExc && !flushReq;
            // past the delay slot is wrong path.
            commitValid1 <= retireValid && s1.valid && !s1.isBubble
                            && !s1.causeExc && !waitDelaySlot && !flushReq;
        end
    end

    always_ff @(posedge clk) begin
        if (isBranch0) begin
            targetQ <= target;                // held across a delay-slot wait.
        end
        excKindQ <= s0.excKind;

        commitReq0.wrReg    <= s0.dstWe;
        commitReq0.archReg  <= s0.dstArch;
        commitReq0.physReg  <= s0.dstPhys;
        commitReq0.staleReg <= s0.dstStale;

        commitReq1.wrReg    <= s1.dstWe;
        commitReq1.archReg  <= s1.dstArch;
        commitReq1.physReg  <= s1.dstPhys;
        commitReq1.staleReg <= s1.dstStale;
    end

    assign flushReq = mispredQ || waitDoneQ || excQ;

    always_comb begin
        redirect.valid = flushReq;
        redirect.pc    = excQ ? `EXC_VECTOR : targetQ;
        excCode        = excQ ? excKindQ : none;
    end

endmodule

/* hw/commitTop.sv */
`timescale 1ns/1ps
`include "commit_defines.svh"

module commitTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   enqValid,
    input  commitPkg::retireEntry  enqEntry,
    output logic                   robFull,
    output commitPkg::redirectInfo redirect,
    output commitPkg::excKind      excCode,
    input  logic [`AREG_W-1:0]     archReadAddr,
    output logic [`PREG_W-1:0]     archReadPhys,
    output logic                   freeValid0,
    output logic                   freeValid1,
    output logic [`PREG_W-1:0]     freeReg0,
    output logic [`PREG_W-1:0]     freeReg1
);

    import commitPkg::*;

    logic       retireValid;
    retirePair  retire;
    logic       flushReq;
    logic       commitValid0;
    logic       commitValid1;
    commitReq   commitReq0;
    commitReq   commitReq1;

    robHead uRobHead (
        .clk         (clk),
        .rstN        (rstN),
        .enqValid    (enqValid),
        .enqEntry    (enqEntry),
        .flushReq    (flushReq),
        .retireValid (retireValid),
        .retire      (retire),
        .robFull     (robFull)
    );

    commitStage uCommitStage (
        .clk          (clk),
        .rstN         (rstN),
        .retireValid  (retireValid),
        .retire       (retire),
        .flushReq     (flushReq),
        .redirect     (redirect),
        .excCode      (excCode),
        .commitValid0 (commitValid0),
        .commitValid1 (commitValid1),
        .commitReq0   (commitReq0),
        .commitReq1   (commitReq1)
    );

    archMapUpdate uArchMapUpdate (
        .clk          (clk),
        .rstN         (rstN),
        .commitValid0 (commitValid0),
        .commitValid1 (commitValid1),
        .commitReq0   (commitReq0),
        .commitReq1   (commitReq1),
        .archReadAddr (archReadAddr),
        .archReadPhys (archReadPhys),
        .freeValid0   (freeValid0),
        .freeValid1   (freeValid1),
        .freeReg0     (freeReg0),
        .freeReg1     (freeReg1)
    );

endmodule

/* hw/robHead/robHead.sv */
`timescale 1ns/1ps
`include "commit_defines.svh"

module robHead (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enqValid,
    input  commitPkg::retireEntry enqEntry,
    input  logic                  flushReq,
    output logic                  retireValid,
    output commitPkg::retirePair  retire,
    output logic                  robFull
);

    import commitPkg::*;

    retireEntry              mem [`ROB_DEPTH];
    logic [`ROB_IDX_W-1:0]   head;
    logic [`ROB_IDX_W-1:0]   tail;
    logic [`ROB_IDX_W:0]     count;
    logic [`ROB_IDX_W-1:0]   headNext;
    logic                    doEnq;
    logic [1:0]              retireNum;
    retireEntry              entry0;
    retireEntry              entry1;

    assign headNext = `ROB_IDX_W'(head + 1'b1);
    assign entry0   = mem[head];
    assign entry1   = mem[headNext];
    assign robFull  = (count == `ROB_DEPTH);
    assign doEnq    = enqValid && !robFull;

    // how many entries leave the head this cycle.
    always_comb begin
        retireNum = 2'd0;
        if (count != 0) begin
            if (entry0.causeExc) begin
                retireNum = 2'd1;             // exception goes alone.
            end else if (entry0.branchKind != normal) begin
                // branch waits for its delay slot or a bubble.
                if (count >= 2) begin
                    retireNum = 2'd2;
                end
            end else if (count >= 2 && entry1.branchKind == normal && !entry1.causeExc) begin
                retireNum = 2'd2;
            end else begin
                retireNum = 2'd1;
            end
        end
        if (flushReq) begin
            retireNum = 2'd0;                 // wrong path behind a flush.
        end
    end

    always_comb begin
        retire.slot0       = entry0;
        retire.slot1       = entry1;
        retire.slot0.valid = (retireNum != 2'd0);
        retire.slot1.valid = (retireNum == 2'd2);
    end

    assign retireValid = (retireNum != 2'd0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flushReq) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= `ROB_IDX_W'(head + retireNum);
            count <= count + doEnq - retireNum;
            if (doEnq) begin
                tail <= `ROB_IDX_W'(tail + 1'b1);
            end
        end
    end

    // payload storage.
    always_ff @(posedge clk) begin
        if (doEnq) begin
            mem[tail] <= enqEntry;
        end
    end

endmodule

/* verification/commitTb.sv */
`timescale 1ns/1ps
`include "commit_defines.svh"

module commitTb;

    import commitPkg::*;

    typedef struct {
        retireEntry  e;
        bit          hasFree;    // stale tag expected back.
        int          gap;        // idle cycles before this row.
        bit          last;       // closes a scenario.
        bit          hasRedir;
        logic [31:0] redirPc;
        excKind      exc;
    } tbRow;

    logic               clk;
    logic               rstN;
    logic               enqValid;
    retireEntry         enqEntry;
    logic               robFull;
    redirectInfo        redirect;
    excKind             excCode;
    logic [`AREG_W-1:0] archReadAddr;
    logic [`PREG_W-1:0] archReadPhys;
    logic               freeValid0;
    logic               freeValid1;
    logic [`PREG_W-1:0] freeReg0;
    logic [`PREG_W-1:0] freeReg1;

    tbRow               rows[$];
    logic [`PREG_W-1:0] expFree[$];
    logic [`PREG_W-1:0] gotFree[$];
    logic [31:0]        expRedir[$];
    logic [31:0]        gotRedir[$];
    logic [31:0]        expRedirT[$];
    logic [31:0]        gotRedirT[$];
    excKind             expExc[$];
    excKind             gotExc[$];
    logic [`PREG_W-1:0] mapModel [32];
    int                 errors = 0;
    int                 checks = 0;
    int                 timeouts = 0;
    int                 seed = 32'hc40a;

    commitTop UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // freed tags and redirects in arrival order.
    always @(negedge clk) begin
        if (rstN) begin
            if (freeValid0) gotFree.push_back(freeReg0);
            if (freeValid1) gotFree.push_back(freeReg1);
            if (redirect.valid) begin
                gotRedir.push_back(redirect.pc);
                gotExc.push_back(excCode);
                gotRedirT.push_back(32'($time));
            end
        end
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    function automatic retireEntry mkOp(logic [31:0] pc, logic [4:0] arch,
                                        logic [5:0] phys, logic [5:0] stale);
        retireEntry e;
        e          = '0;
        e.valid    = 1'b1;
        e.pc       = pc;
        e.dstWe    = 1'b1;
        e.dstArch  = arch;
        e.dstPhys  = phys;
        e.dstStale = stale;
        return e;
    endfunction

    function automatic retireEntry mkBranch(logic [31:0] pc, branchKind kind, logic taken,
                                            logic [31:0] addr, logic predT, logic [31:0] predA);
        retireEntry e;
        e             = '0;
        e.valid       = 1'b1;
        e.pc          = pc;
        e.branchKind  = kind;
        e.branchTaken = taken;
        e.branchAddr  = addr;
        e.predTaken   = predT;
        e.predAddr    = predA;
        return e;
    endfunction

    task automatic addRow(input retireEntry e, input bit hasFree, input int gap, input bit last,
                          input bit hasRedir, input logic [31:0] redirPc, input excKind exc);
        tbRow r;
        r.e        = e;
        r.hasFree  = hasFree;
        r.gap      = gap;
        r.last     = last;
        r.hasRedir = hasRedir;
        r.redirPc  = redirPc;
        r.exc      = exc;
        rows.push_back(r);
    endtask

    task automatic loadTable();
        retireEntry e;
        int         gap;
        // in-order frees, r0 write is freed but not mapped.
        addRow(mkOp(32'h100, 5'd1, 6'd32, 6'd1), 1, 0, 0, 0, 0, none);
        addRow(mkOp(32'h104, 5'd2, 6'd33, 6'd2), 1, 0, 0, 0, 0, none);
        addRow(mkOp(32'h108, 5'd1, 6'd34, 6'd32), 1, 0, 0, 0, 0, none);
        addRow(mkOp(32'h10c, 5'd0, 6'd35, 6'd0), 1, 0, 1, 0, 0, none);
        // correctly predicted.
        addRow(mkBranch(32'h200, conditional, 1, 32'h300, 1, 32'h300), 0, 0, 0, 0, 0, none);
        addRow(mkOp(32'h204, 5'd3, 6'd36, 6'd3), 1, 0, 1, 0, 0, none);
        // direction misses, delay slot present.
        addRow(mkBranch(32'h300, conditional, 0, 32'h380, 1, 32'h380), 0, 0, 0, 0, 0, none);
        addRow(mkOp(32'h304, 5'd4, 6'd37, 6'd4), 1, 0, 1, 1, 32'h308, none);
        addRow(mkBranch(32'h400, conditional, 1, 32'h480, 0, 32'h0), 0, 0, 0, 0, 0, none);
        addRow(mkOp(32'h404, 5'd5, 6'd38, 6'd5), 1, 0, 1, 1, 32'h480, none);
        // bubble first, delay slot after a random gap.
        gap = $unsigned($random(seed)) % 4;
        e = mkBranch(32'h0, normal, 0, 32'h0, 0, 32'h0);
        e.isBubble = 1'b1;
        addRow(mkBranch(32'h500, conditional, 1, 32'h540, 0, 32'h0), 0, 0, 0, 0, 0, none);
        addRow(e, 0, 0, 0, 0, 0, none);
        addRow(mkOp(32'h504, 5'd6, 6'd39, 6'd6), 1, gap, 1, 1, 32'h540, none);
        // target miss on a jump.
        addRow(mkBranch(32'h600, jump, 1, 32'h700, 1, 32'h680), 0, 0, 0, 0, 0, none);
        addRow(mkOp(32'h604, 5'd7, 6'd40, 6'd7), 1, 0, 1, 1, 32'h700, none);
        // exception, the two behind it are dropped.
        e = mkOp(32'h800, 5'd8, 6'd41, 6'd8);
        e.causeExc = 1'b1;
        e.excKind  = overflow;
        addRow(e, 0, 0, 0, 1, `EXC_VECTOR, overflow);
        addRow(mkOp(32'h804, 5'd9, 6'd42, 6'd9), 0, 0, 0, 0, 0, none);
        addRow(mkOp(32'h808, 5'd10, 6'd43, 6'd10), 0, 0, 1, 0, 0, none);
        // link write and delay slot hit the same register.
        e = mkBranch(32'h900, jump, 1, 32'ha00, 1, 32'ha00);
        e.dstWe    = 1'b1;
        e.dstArch  = 5'd31;
        e.dstPhys  = 6'd44;
        e.dstStale = 6'd31;
        addRow(e, 1, 0, 0, 0, 0, none);
        addRow(mkOp(32'h904, 5'd31, 6'd45, 6'd44), 1, 0, 1, 0, 0, none);
    endtask

    task automatic waitScenario();
        int cyc;
        for (cyc = 0; cyc < 50; cyc++) begin
            if (gotFree.size() >= expFree.size() && gotRedir.size() >= expRedir.size()) break;
            @(negedge clk);
        end
        if (cyc == 50) begin
            timeouts++;
            $display("timeout: scenario results did not arrive at time %0t", $time);
        end
    endtask

    initial begin
        rstN         = 1'b0;
        enqValid     = 1'b0;
        enqEntry     = '0;
        archReadAddr = '0;
        for (int i = 0; i < 32; i++) mapModel[i] = `PREG_W'(i);
        loadTable();
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        foreach (rows[i]) begin
            repeat (rows[i].gap) begin
                enqValid = 1'b0;
                @(negedge clk);
            end
            checkVal("robFull", robFull, 1'b0);
            enqValid = 1'b1;
            enqEntry = rows[i].e;
            if (rows[i].hasFree) begin
                expFree.push_back(rows[i].e.dstStale);
                if (rows[i].e.dstArch != 0) mapModel[rows[i].e.dstArch] = rows[i].e.dstPhys;
            end
            if (rows[i].hasRedir) begin
                expRedir.push_back(rows[i].redirPc);
                expExc.push_back(rows[i].exc);
                expRedirT.push_back(32'($time + 20));   // retire, then the registered stage.
            end
            @(negedge clk);
            enqValid = 1'b0;
            if (rows[i].last) begin
                waitScenario();
                repeat (4) @(negedge clk);   // let a flush settle.
            end
        end
        checkVal("freeCount", gotFree.size(), expFree.size());
        for (int i = 0; i < expFree.size() && i < gotFree.size(); i++)
            checkVal("freeReg", gotFree[i], expFree[i]);
        checkVal("redirectCount", gotRedir.size(), expRedir.size());
        for (int i = 0; i < expRedir.size() && i < gotRedir.size(); i++) begin
            checkVal("redirect.pc", gotRedir[i], expRedir[i]);
            checkVal("excCode", gotExc[i], expExc[i]);
            checkVal("redirectTime", gotRedirT[i], expRedirT[i]);
        end
        for (int i = 0; i < 32; i++) begin
            archReadAddr = `AREG_W'(i);
            #1;
            checkVal($sformatf("archReadPhys[%0d]", i), archReadPhys, mapModel[i]);
        end
        $display("checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/commit_sva.sv */
`timescale 1ns/1ps
`include "commit_defines.svh"

module commitSva (
    input logic                   clk,
    input logic                   rstN,
    input logic                   retireValid,
    input commitPkg::retirePair   retire,
    input logic                   flushReq,
    input commitPkg::redirectInfo redirect,
    input commitPkg::excKind      excCode,
    input logic                   commitValid0,
    input logic                   commitValid1
);

    import commitPkg::*;

    // faulting op goes to the handler next cycle.
    excRedirect: assert property (
        @(posedge clk) disable iff (!rstN)
        (retireValid && retire.slot0.valid && retire.slot0.causeExc && !flushReq)
            |=> (redirect.valid && redirect.pc == `EXC_VECTOR
                 && excCode == $past(retire.slot0.excKind))
    ) else $error("exception retired without a vector redirect");

    // flush lasts a single cycle.
    flushOneCycle: assert property (
        @(posedge clk) disable iff (!rstN) flushReq |=> !flushReq
    ) else $error("flush held for two cycles");

    noCommitOnExc: assert property (
        @(posedge clk) disable iff (!rstN)
        (redirect.valid && excCode != none) |-> (!commitValid0 && !commitValid1)
    ) else $error("commit valid during exception redirect");

endmodule

bind commitStage commitSva uCommitSva (
    .clk          (clk),
    .rstN         (rstN),
    .retireValid  (retireValid),
    .retire       (retire),
    .flushReq     (flushReq),
    .redirect     (redirect),
    .excCode      (excCode),
    .commitValid0 (commitValid0),
    .commitValid1 (commitValid1)
);
